/* all.f */
+incdir+include
verilog/glue_pkg.sv
verilog/addr_decode.sv
verilog/input_readback.sv
verilog/system_control.sv
verilog/layer_mixer.sv
verilog/glue_top.sv
verif/tb_clock.sv
verif/glue_tb.sv

/* include/glue_settings.svh */
`ifndef GLUE_SETTINGS_SVH
`define GLUE_SETTINGS_SVH

// single addresses
`define GLUE_IN0_ADDR      16'h8000
`define GLUE_VIDCTL_ADDR   16'h8001
`define GLUE_PAUSE_ADDR    16'h8530
`define GLUE_MENU_ADDR     16'h8531

// ranges, base inclusive and limit exclusive
`define GLUE_TS_BASE       16'h8080
`define GLUE_TS_LIMIT      16'h80A0
`define GLUE_TIMER_BASE    16'h80C0
`define GLUE_TIMER_LIMIT   16'h80D0
`define GLUE_JOY_BASE      16'h8100
`define GLUE_JOY_LIMIT     16'h81C0
`define GLUE_PAD_BASE      16'h8300
`define GLUE_PAD_LIMIT     16'h8330
`define GLUE_KEY_BASE      16'h8400
`define GLUE_KEY_LIMIT     16'h840C

// 24 MHz clock cycles per millisecond tick
`define GLUE_TIMER_DIV     24000

// host port counts
`define GLUE_JOY_PORTS     6
`define GLUE_JOY_BITS      32
`define GLUE_PAD_PORTS     6

// fixed bit pair in the middle of the status byte
`define GLUE_STATUS_FIXED  2'b10

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# builds the glue testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module glue_tb \
	-f all.f -o glue_sim > build.log 2>&1 \
	&& ./obj_dir/glue_sim > sim.log 2>&1 \
	|| { echo "build or run failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* verif/glue_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "glue_settings.svh"

module glue_tb
	import glue_pkg::*;
();

	logic clk_24;
	logic rst;
	logic pause;
	logic menu;
	cpu_bus_t bus;
	host_in_t host;
	vid_sync_t sync;
	layer_pix_t spr;
	layer_pix_t chr;
	layer_pix_t tile;
	logic [7:0] cpu_din;
	logic cpu_wait;
	rgb_t rgb;

	int errors;
	int checks;
	int tests;

	tb_clock i_clock (
		.clk_24 (clk_24),
		.rst    (rst)
	);

	glue_top i_dut (
		.clk_24   (clk_24),
		.rst      (rst),
		.pause    (pause),
		.menu     (menu),
		.bus      (bus),
		.host     (host),
		.sync     (sync),
		.spr      (spr),
		.chr      (chr),
		.tile     (tile),
		.cpu_din  (cpu_din),
		.cpu_wait (cpu_wait),
		.rgb      (rgb)
	);

	// step to 1 ns past the next rising edge where inputs change
	task automatic next_cycle();
		@(posedge clk_24);
		#1;
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic finish_test(input string title, input int start_errors);
		tests++;
		if (errors == start_errors)
			$display("test %s: ok", title);
		else
			$display("test %s: %0d errors", title, errors - start_errors);
	endtask

	task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
		next_cycle();
		bus.addr = addr;
		bus.dout = data;
		bus.wr = 1'b1;
		next_cycle();
		bus.wr = 1'b0;
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [7:0] exp);
		next_cycle();
		bus.addr = addr;
		bus.wr = 1'b0;
		#2;
		check_byte($sformatf("cpu_din@%h", addr), cpu_din, exp);
	endtask

	// byte idx of a little-endian source with bits past its width as 0
	function automatic logic [7:0] expected_byte(input logic [255:0] src, input int width,
		input int idx);
		logic [7:0] r;
		int b;
		r = 8'h00;
		for (b = 0; b < 8; b++)
		begin
			if (idx * 8 + b < width)
				r[b] = src[idx * 8 + b];
		end
		return r;
	endfunction

	task automatic read_range(input logic [15:0] base, input logic [15:0] limit,
		input logic [255:0] src, input int width, input int idx_bits);
		int a;
		int idx;
		for (a = base; a < limit; a++)
		begin
			idx = a % (1 << idx_bits);
			read_expect(16'(a), expected_byte(src, width, idx));
		end
	endtask

	function automatic rgb_t expected_mix(input logic sprite_high, input layer_pix_t s,
		input layer_pix_t c, input layer_pix_t t);
		if (sprite_high && s.a)
			return s.rgb;
		if (c.a)
			return c.rgb;
		if (s.a)
			return s.rgb;
		if (t.a)
			return t.rgb;
		return '0;
	endfunction

	task automatic test_readback();
		int start_errors;
		int i;
		start_errors = errors;
		for (i = 0; i < 6; i++)
			host.joystick[i * 32 +: 32] = $urandom();
		host.paddle = {16'($urandom()), 32'($urandom())};
		host.ps2_key = 11'($urandom());
		host.timestamp = {1'($urandom()), 32'($urandom())};
		// full ranges cover the bytes past each source's width
		read_range(`GLUE_JOY_BASE, `GLUE_JOY_LIMIT, 256'(host.joystick), 192, 5);
		read_range(`GLUE_PAD_BASE, `GLUE_PAD_LIMIT, 256'(host.paddle), 48, 3);
		read_range(`GLUE_KEY_BASE, `GLUE_KEY_LIMIT, 256'(host.ps2_key), 11, 1);
		read_range(`GLUE_TS_BASE, `GLUE_TS_LIMIT, 256'(host.timestamp), 33, 3);
		read_expect(16'h81C0, 8'h00);
		read_expect(16'h8330, 8'h00);
		read_expect(16'h840C, 8'h00);
		read_expect(16'h80A0, 8'h00);
		read_expect(16'h8200, 8'h00);
		finish_test("input readback", start_errors);
	endtask

	task automatic test_status();
		int start_errors;
		int v;
		logic [7:0] exp;
		start_errors = errors;
		for (v = 0; v < 32; v++)
		begin
			next_cycle();
			sync.hs = v[4];
			sync.vs = v[3];
			sync.hblank = v[2];
			sync.vblank = v[1];
			menu = v[0];
			// hs down to vblank, fixed 10, menu, then 0
			exp = {v[4:1], 2'b10, v[0], 1'b0};
			read_expect(`GLUE_IN0_ADDR, exp);
		end
		menu = 1'b0;
		finish_test("status byte", start_errors);
	endtask

	task automatic test_pause();
		int start_errors;
		start_errors = errors;
		next_cycle();
		check_bit("cpu_wait", cpu_wait, 1'b0);
		write_reg(`GLUE_PAUSE_ADDR, 8'h01);
		#2;
		check_bit("cpu_wait", cpu_wait, 1'b1);
		// a pulse on the pause input releases the trigger
		next_cycle();
		pause = 1'b1;
		next_cycle();
		pause = 1'b0;
		#2;
		check_bit("cpu_wait", cpu_wait, 1'b0);
		// the pause input alone holds the cpu as well
		next_cycle();
		pause = 1'b1;
		#2;
		check_bit("cpu_wait", cpu_wait, 1'b1);
		next_cycle();
		pause = 1'b0;
		#2;
		check_bit("cpu_wait", cpu_wait, 1'b0);
		finish_test("pause", start_errors);
	endtask

	task automatic test_menu();
		int start_errors;
		start_errors = errors;
		// clear the request left over from the status test
		write_reg(`GLUE_MENU_ADDR, 8'h00);
		read_expect(`GLUE_MENU_ADDR, 8'h00);
		next_cycle();
		menu = 1'b1;
		next_cycle();
		menu = 1'b0;
		read_expect(`GLUE_MENU_ADDR, 8'hFF);
		write_reg(`GLUE_MENU_ADDR, 8'h00);
		read_expect(`GLUE_MENU_ADDR, 8'h00);
		finish_test("menu", start_errors);
	endtask

	task automatic test_timer();
		int start_errors;
		start_errors = errors;
		// let the count running since reset reach 1 before the restart
		repeat (`GLUE_TIMER_DIV) @(posedge clk_24);
		read_expect(`GLUE_TIMER_BASE, 8'h01);
		write_reg(`GLUE_TIMER_BASE, 8'h00);
		// half a tick of margin either side of the third increment
		repeat (3 * `GLUE_TIMER_DIV + `GLUE_TIMER_DIV / 2) @(posedge clk_24);
		read_expect(`GLUE_TIMER_BASE, 8'h03);
		read_expect(`GLUE_TIMER_BASE + 16'd1, 8'h00);
		finish_test("timer", start_errors);
	endtask

	task automatic test_mixer();
		int start_errors;
		int sh;
		int combo;
		rgb_t exp;
		start_errors = errors;
		for (sh = 0; sh < 2; sh++)
		begin
			write_reg(`GLUE_VIDCTL_ADDR, 8'(sh));
			for (combo = 0; combo < 8; combo++)
			begin
				next_cycle();
				spr = {24'($urandom()), combo[2]};
				chr = {24'($urandom()), combo[1]};
				tile = {24'($urandom()), combo[0]};
				exp = expected_mix(sh[0], spr, chr, tile);
				next_cycle();
				check_rgb($sformatf("rgb sh=%0d a=%0d", sh, combo), rgb, exp);
			end
		end
		finish_test("mixer priority", start_errors);
	endtask

	// the timer test dominates the run length
	initial
	begin
		repeat (5 * `GLUE_TIMER_DIV + 2000) @(posedge clk_24);
		$display("watchdog expired before the tests finished");
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h0c41_f52b));
		errors = 0;
		checks = 0;
		tests = 0;
		pause = 1'b0;
		menu = 1'b0;
		bus = '0;
		host = '0;
		sync = '0;
		spr = '0;
		chr = '0;
		tile = '0;
		wait (rst === 1'b0);
		next_cycle();
		test_readback();
		test_status();
		test_pause();
		test_menu();
		test_timer();
		test_mixer();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
	output logic clk_24,
	output logic rst
);

	// 4 ns period
	initial
	begin
		clk_24 = 1'b0;
		forever #2 clk_24 = ~clk_24;
	end

	// reset held over the first 10 rising edges
	initial
	begin
		rst = 1'b1;
		repeat (10) @(posedge clk_24);
		#1 rst = 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "glue_settings.svh"

module addr_decode
	import glue_pkg::*;
(
	input wire cpu_bus_t bus,
	output chip_sel_t sel,
	output chip_sel_t wsel
);

	mmio_addr_u addr_view;

	// base inclusive, limit exclusive
	function automatic logic in_range(
		input logic [15:0] a,
		input logic [15:0] base,
		input logic [15:0] limit
	);
		return (a >= base) && (a < limit);
	endfunction

	assign addr_view = bus.addr;

	always_comb
	begin
		sel = '0;

		// single register addresses
		sel.in0 = (addr_view.word == `GLUE_IN0_ADDR);
		sel.vidctl = (addr_view.word == `GLUE_VIDCTL_ADDR);
		sel.pause = (addr_view.word == `GLUE_PAUSE_ADDR);
		sel.menu = (addr_view.word == `GLUE_MENU_ADDR);

		// multi-byte sources
		sel.ts = in_range(addr_view.word, `GLUE_TS_BASE, `GLUE_TS_LIMIT);
		sel.timer = in_range(addr_view.word, `GLUE_TIMER_BASE, `GLUE_TIMER_LIMIT);
		sel.joy = in_range(addr_view.word, `GLUE_JOY_BASE, `GLUE_JOY_LIMIT);
		sel.pad = in_range(addr_view.word, `GLUE_PAD_BASE, `GLUE_PAD_LIMIT);
		sel.key = in_range(addr_view.word, `GLUE_KEY_BASE, `GLUE_KEY_LIMIT);
	end

	// write strobes only live for the cycle wr is high
	always_comb
	begin
		if (bus.wr)
		begin
			wsel = sel;
		end
		else
		begin
			wsel = '0;
		end
	end

endmodule

`default_nettype wire

/* verilog/glue_pkg.sv */
`default_nettype none
`include "glue_settings.svh"

package glue_pkg;

	// cpu side of the bus, wr is a one cycle strobe
	typedef struct packed {
		logic [15:0] addr;
		logic        wr;
		logic [7:0]  dout;
	} cpu_bus_t;

	typedef struct packed {
		logic [7:0] page;
		logic [7:0] offset;
	} mmio_page_t;

	// flat word for range compares, page/offset for byte selection
	typedef union packed {
		logic [15:0] word;
		mmio_page_t  paged;
	} mmio_addr_u;

	typedef struct packed {
		logic in0;
		logic vidctl;
		logic ts;
		logic timer;
		logic joy;
		logic pad;
		logic key;
		logic pause;
		logic menu;
	} chip_sel_t;

	typedef struct packed {
		logic [`GLUE_JOY_PORTS*`GLUE_JOY_BITS-1:0] joystick;
		// one byte per paddle
		logic [`GLUE_PAD_PORTS*8-1:0] paddle;
		logic [10:0] ps2_key;
		logic [32:0] timestamp;
	} host_in_t;

	typedef struct packed {
		logic hs;
		logic vs;
		logic hblank;
		logic vblank;
	} vid_sync_t;

	typedef struct packed {
		logic [7:0] b;
		logic [7:0] g;
		logic [7:0] r;
	} rgb_t;

	typedef struct packed {
		rgb_t rgb;
		logic a;
	} layer_pix_t;

endpackage

`default_nettype wire

/* verilog/glue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module glue_top
	import glue_pkg::*;
(
	input wire logic clk_24,
	input wire logic rst,
	input wire logic pause,
	input wire logic menu,
	input wire cpu_bus_t bus,
	input wire host_in_t host,
	input wire vid_sync_t sync,
	input wire layer_pix_t spr,
	input wire layer_pix_t chr,
	input wire layer_pix_t tile,
	output logic [7:0] cpu_din,
	output logic cpu_wait,
	output rgb_t rgb
);

	chip_sel_t sel;
	chip_sel_t wsel;
	logic sprite_high;
	logic [15:0] timer_count;
	logic menu_flag;

	addr_decode i_addr_decode (
		.bus  (bus),
		.sel  (sel),
		.wsel (wsel)
	);

	input_readback i_input_readback (
		.sel         (sel),
		.addr        (bus.addr),
		.host        (host),
		.sync        (sync),
		.menu        (menu),
		.timer_count (timer_count),
		.menu_flag   (menu_flag),
		.cpu_din     (cpu_din)
	);

	system_control i_system_control (
		.clk_24      (clk_24),
		.rst         (rst),
		.pause       (pause),
		.menu        (menu),
		.wsel        (wsel),
		.dout        (bus.dout),
		.cpu_wait    (cpu_wait),
		.sprite_high (sprite_high),
		.timer_count (timer_count),
		.menu_flag   (menu_flag)
	);

	layer_mixer i_layer_mixer (
		.clk_24      (clk_24),
		.rst         (rst),
		.spr         (spr),
		.chr         (chr),
		.tile        (tile),
		.sprite_high (sprite_high),
		.rgb         (rgb)
	);

endmodule

`default_nettype wire

/* verilog/input_readback.sv */
`timescale 1ns/1ps
`default_nettype none
`include "glue_settings.svh"

module input_readback
	import glue_pkg::*;
(
	input wire chip_sel_t sel,
	input wire mmio_addr_u addr,
	input wire host_in_t host,
	input wire vid_sync_t sync,
	input wire logic menu,
	input wire logic [15:0] timer_count,
	input wire logic menu_flag,
	output logic [7:0] cpu_din
);

	logic [7:0] status_byte;
	logic [7:0] joy_byte;
	logic [7:0] pad_byte;
	logic [7:0] key_byte;
	logic [7:0] ts_byte;
	logic [7:0] timer_byte;

	// source is zero padded to 256 bits, so bytes past its width read 0
	function automatic logic [7:0] pick_byte(
		input logic [255:0] src,
		input logic [4:0] idx
	);
		return src[{idx, 3'b000} +: 8];
	endfunction

	assign status_byte = {
		sync.hs,
		sync.vs,
		sync.hblank,
		sync.vblank,
		`GLUE_STATUS_FIXED,
		menu,
		1'b0
	};

	// low offset bits pick the byte within each source
	assign joy_byte = pick_byte(256'(host.joystick), addr.paged.offset[4:0]);
	assign pad_byte = pick_byte(256'(host.paddle), {2'b00, addr.paged.offset[2:0]});
	assign key_byte = pick_byte(256'(host.ps2_key), {4'b0000, addr.paged.offset[0]});
	assign ts_byte = pick_byte(256'(host.timestamp), {2'b00, addr.paged.offset[2:0]});
	assign timer_byte = pick_byte(256'(timer_count), {4'b0000, addr.paged.offset[0]});

	// selects are disjoint, order here does not matter
	always_comb
	begin
		if (sel.in0)
		begin
			cpu_din = status_byte;
		end
		else if (sel.joy)
		begin
			cpu_din = joy_byte;
		end
		else if (sel.pad)
		begin
			cpu_din = pad_byte;
		end
		else if (sel.key)
		begin
			cpu_din = key_byte;
		end
		else if (sel.ts)
		begin
			cpu_din = ts_byte;
		end
		else if (sel.timer)
		begin
			cpu_din = timer_byte;
		end
		else if (sel.menu)
		begin
			cpu_din = {8{menu_flag}};
		end
		else
		begin
			cpu_din = 8'h00;
		end
	end

endmodule

`default_nettype wire

/* verilog/layer_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_mixer
	import glue_pkg::*;
(
	input wire logic clk_24,
	input wire logic rst,
	input wire layer_pix_t spr,
	input wire layer_pix_t chr,
	input wire layer_pix_t tile,
	input wire logic sprite_high,
	output rgb_t rgb
);

	rgb_t mixed;

	// first opaque layer wins, black when nothing is opaque
	always_comb
	begin
		mixed = '0;
		if (tile.a)
		begin
			mixed = tile.rgb;
		end
		if (sprite_high)
		begin
			if (spr.a)
				mixed = spr.rgb;
			else if (chr.a)
				mixed = chr.rgb;
		end
		else
		begin
			if (chr.a)
				mixed = chr.rgb;
			else if (spr.a)
				mixed = spr.rgb;
		end
	end

	always_ff @(posedge clk_24)
	begin
		if (rst)
		begin
			rgb <= '0;
		end
		else
		begin
			rgb <= mixed;
		end
	end

endmodule

`default_nettype wire

/* verilog/system_control.sv */
`timescale 1ns/1ps
`default_nettype none
`include "glue_settings.svh"

module system_control
	import glue_pkg::*;
(
	input wire logic clk_24,
	input wire logic rst,
	input wire logic pause,
	input wire logic menu,
	input wire chip_sel_t wsel,
	input wire logic [7:0] dout,
	output logic cpu_wait,
	output logic sprite_high,
	output logic [15:0] timer_count,
	output logic menu_flag
);

	localparam int PRE_W = $clog2(`GLUE_TIMER_DIV);
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`GLUE_TIMER_DIV - 1);

	logic [7:0] vid_ctl;
	logic pause_trig;
	logic [PRE_W-1:0] prescale;

	always_ff @(posedge clk_24)
	begin
		if (rst)
		begin
			vid_ctl <= 8'h00;
		end
		else if (wsel.vidctl)
		begin
			vid_ctl <= dout;
		end
	end

	// bit 0 puts sprites above the character layer
	assign sprite_high = vid_ctl[0];

	// software sets the pause, the host pause input releases it
	always_ff @(posedge clk_24)
	begin
		if (rst)
		begin
			pause_trig <= 1'b0;
		end
		else
		begin
			if (wsel.pause)
			begin
				pause_trig <= 1'b1;
			end
			if (pause)
			begin
				pause_trig <= 1'b0;
			end
		end
	end

	assign cpu_wait = pause | pause_trig;

	// host sets the menu request, software acknowledges it
	always_ff @(posedge clk_24)
	begin
		if (rst)
		begin
			menu_flag <= 1'b0;
		end
		else
		begin
			if (menu)
			begin
				menu_flag <= 1'b1;
			end
			if (wsel.menu)
			begin
				menu_flag <= 1'b0;
			end
		end
	end

	// millisecond counter, any write to the timer range restarts it
	always_ff @(posedge clk_24)
	begin
		if (rst || wsel.timer)
		begin
			prescale <= '0;
			timer_count <= 16'h0000;
		end
		else if (prescale == PRE_LAST)
		begin
			prescale <= '0;
			timer_count <= timer_count + 16'd1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

`default_nettype wire
